// File: include/mem_defs.svh
// Memory subsystem widths, client indices, burst timing and frame geometry
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Memory bus
`define MEM_AW 10
`define MEM_DW 16
`define MEM_CLIENTS 2
`define MEM_BURST 8
`define MEM_RD_LAT 2
`define CMD_DEPTH 4

// Frame buffer placement and size
`define FB_BASE 'h100
`define FB_WIDTH 16
`define FB_HEIGHT 4
`define PIX_DEPTH 16

// Arbiter port assignment
`define CLIENT_DISP 0
`define CLIENT_TEST 1

`endif

// File: source/mem_pkg.sv
// Memory bus types: word address, data word, client index and queued command
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

	// Word address into the shared memory
	typedef logic [`MEM_AW-1:0] addr_t;

	// One memory word
	typedef logic [`MEM_DW-1:0] data_t;

	// Requesting client, also used to route read data
	typedef logic [$clog2(`MEM_CLIENTS)-1:0] client_t;

	// Queued command, a read fetches a whole burst from addr
	typedef struct packed {
		addr_t addr;
		logic wr;
		data_t wdata;
		client_t client;
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: source/disp_pkg.sv
// Display types: RGB565 pixel and the position inside the frame
`default_nettype none

`include "mem_defs.svh"

package disp_pkg;

	// One memory word holds exactly one pixel
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} pixel_t;

	typedef struct packed {
		logic [$clog2(`FB_HEIGHT)-1:0] line;
		logic [$clog2(`FB_WIDTH)-1:0] col;
	} pix_pos_t;

endpackage

`default_nettype wire

// File: source/burst_fifo.sv
// First-word-fall-through synchronous FIFO with a type parameter for the payload
`timescale 1ns/1ps
`default_nettype none

module burst_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic CLOCK_50,
	input logic rst,
	input logic push,
	input T din,
	input logic pop,
	output T dout,
	output logic empty,
	output logic full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

T mem [DEPTH];
logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic do_push;
logic do_pop;

assign do_push = push && !full;
assign do_pop = pop && !empty;
assign empty = (count == '0);
assign full = (int'(count) == DEPTH);

// Head entry is visible without a pop
assign dout = mem[rd_ptr];

always_ff @(posedge CLOCK_50) begin
	if (do_push)
		mem[wr_ptr] <= din;
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (do_push)
			wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
		if (do_push && !do_pop)
			count <= count + 1'b1;
		else if (do_pop && !do_push)
			count <= count - 1'b1;
	end
end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
// Round-robin memory arbiter feeding a command queue
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_arbiter (
	input logic CLOCK_50,
	input logic rst,
	input logic req [`MEM_CLIENTS],
	input logic wr [`MEM_CLIENTS],
	input mem_pkg::addr_t addr [`MEM_CLIENTS],
	input mem_pkg::data_t wdata [`MEM_CLIENTS],
	output logic [`MEM_CLIENTS-1:0] ack,
	input logic cmd_pop,
	output mem_pkg::mem_cmd_t cmd,
	output logic cmd_empty
);

mem_pkg::client_t last;
mem_pkg::client_t win;
logic win_valid;
logic push;
logic full;
mem_pkg::mem_cmd_t new_cmd;

// Search starts just after the last served client
always_comb begin
	int idx;
	win_valid = 1'b0;
	win = '0;
	for (int i = `MEM_CLIENTS; i >= 1; i--) begin
		idx = (int'(last) + i) % `MEM_CLIENTS;
		if (req[idx]) begin
			win_valid = 1'b1;
			win = mem_pkg::client_t'(idx);
		end
	end
end

// Acknowledge only together with the push
assign push = win_valid && !full;

always_comb begin
	for (int c = 0; c < `MEM_CLIENTS; c++)
		ack[c] = push && (int'(win) == c);
end

assign new_cmd = '{addr: addr[win], wr: wr[win], wdata: wdata[win], client: win};

always_ff @(posedge CLOCK_50) begin
	if (rst)
		last <= mem_pkg::client_t'(`CLIENT_TEST);
	else if (push)
		last <= win;
end

burst_fifo #(
	.T(mem_pkg::mem_cmd_t),
	.DEPTH(`CMD_DEPTH)
) u_cmd_fifo (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.push(push),
	.din(new_cmd),
	.pop(cmd_pop),
	.dout(cmd),
	.empty(cmd_empty),
	.full(full),
	.count()
);

endmodule

`default_nettype wire

// File: source/burst_mem.sv
// Shared word memory with single writes, burst reads and per-client read routing
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module burst_mem (
	input logic CLOCK_50,
	input logic rst,
	input mem_pkg::mem_cmd_t cmd,
	input logic cmd_empty,
	output logic cmd_pop,
	output mem_pkg::data_t rdata,
	output logic [`MEM_CLIENTS-1:0] rvalid
);

typedef enum logic [1:0] {S_IDLE, S_LAT, S_BEAT} state_t;

localparam int LW = $clog2(`MEM_RD_LAT + 1);
localparam int BW = $clog2(`MEM_BURST);

mem_pkg::data_t mem [2**`MEM_AW];
state_t state;
logic [LW-1:0] lat_cnt;
logic [BW-1:0] beat_cnt;
mem_pkg::addr_t burst_addr;
mem_pkg::client_t owner;
logic advance;

// Next command is taken only while idle
assign cmd_pop = (state == S_IDLE) && !cmd_empty;

// Read address steps on the last latency cycle and on every beat
assign advance = ((state == S_LAT) && (lat_cnt == '0)) || (state == S_BEAT);

always_comb begin
	for (int c = 0; c < `MEM_CLIENTS; c++)
		rvalid[c] = (state == S_BEAT) && (int'(owner) == c);
end

// Array, registered read port and burst pointer
always_ff @(posedge CLOCK_50) begin
	if (cmd_pop && cmd.wr)
		mem[cmd.addr] <= cmd.wdata;
	rdata <= mem[burst_addr];
	if (cmd_pop) begin
		burst_addr <= cmd.addr;
		owner <= cmd.client;
	end else if (advance) begin
		burst_addr <= burst_addr + 1'b1;
	end
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		lat_cnt <= '0;
		beat_cnt <= '0;
	end else begin
		case (state)
			S_IDLE: if (cmd_pop && !cmd.wr) begin
				state <= S_LAT;
				lat_cnt <= LW'(`MEM_RD_LAT - 2);
			end
			S_LAT: if (lat_cnt == '0) begin
				state <= S_BEAT;
				beat_cnt <= '0;
			end else begin
				lat_cnt <= lat_cnt - 1'b1;
			end
			S_BEAT: begin
				if (beat_cnt == BW'(`MEM_BURST - 1))
					state <= S_IDLE;
				beat_cnt <= beat_cnt + 1'b1;
			end
			default: state <= S_IDLE;
		endcase
	end
end

endmodule

`default_nettype wire

// File: source/disp_fetch.sv
// Display client: frame-buffer burst fetch, pixel buffer and pixel stream with markers
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module disp_fetch (
	input logic CLOCK_50,
	input logic rst,
	input logic enable,
	output logic req,
	output logic wr,
	output mem_pkg::addr_t addr,
	output mem_pkg::data_t wdata,
	input logic ack,
	input mem_pkg::data_t rdata,
	input logic rvalid,
	output disp_pkg::pixel_t pixel,
	output logic pixel_valid,
	input logic pixel_ready,
	output logic line_end,
	output logic frame_end
);

localparam int CW = $clog2(`PIX_DEPTH + 1);
localparam mem_pkg::addr_t LAST_BURST =
	mem_pkg::addr_t'(`FB_BASE + `FB_WIDTH * `FB_HEIGHT - `MEM_BURST);

logic [CW-1:0] buf_count;
logic [CW-1:0] inflight;
logic [CW:0] committed;
logic buf_empty;
logic take;
logic last_col;
logic last_line;
disp_pkg::pix_pos_t pos;
mem_pkg::addr_t fetch_addr;

// Read-only client
assign wr = 1'b0;
assign wdata = '0;
assign addr = fetch_addr;

// Buffered words plus words still on their way
assign committed = {1'b0, buf_count} + {1'b0, inflight};

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		req <= 1'b0;
		fetch_addr <= mem_pkg::addr_t'(`FB_BASE);
		inflight <= '0;
	end else begin
		inflight <= inflight + (ack ? CW'(`MEM_BURST) : CW'(0)) - CW'(rvalid);
		if (ack) begin
			req <= 1'b0;
			if (fetch_addr == LAST_BURST)
				fetch_addr <= mem_pkg::addr_t'(`FB_BASE);
			else
				fetch_addr <= fetch_addr + mem_pkg::addr_t'(`MEM_BURST);
		end else if (enable && !req && int'(committed) <= `PIX_DEPTH - `MEM_BURST) begin
			req <= 1'b1;
		end
	end
end

burst_fifo #(
	.T(disp_pkg::pixel_t),
	.DEPTH(`PIX_DEPTH)
) u_pix_fifo (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.push(rvalid),
	.din(disp_pkg::pixel_t'(rdata)),
	.pop(take),
	.dout(pixel),
	.empty(buf_empty),
	.full(),
	.count(buf_count)
);

assign pixel_valid = !buf_empty;
assign take = pixel_valid && pixel_ready;

// Markers follow the head pixel, so they hold with it
assign last_col = (int'(pos.col) == `FB_WIDTH - 1);
assign last_line = (int'(pos.line) == `FB_HEIGHT - 1);
assign line_end = pixel_valid && last_col;
assign frame_end = pixel_valid && last_col && last_line;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		pos <= '0;
	end else if (take) begin
		if (last_col) begin
			pos.col <= '0;
			pos.line <= last_line ? '0 : pos.line + 1'b1;
		end else begin
			pos.col <= pos.col + 1'b1;
		end
	end
end

endmodule

`default_nettype wire

// File: source/mem_tester.sv
// Memory self-test client: pattern write, burst read-back and compare
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_tester (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input mem_pkg::addr_t base,
	input mem_pkg::data_t seed,
	input logic [7:0] length,
	input logic corrupt,
	output logic req,
	output logic wr,
	output mem_pkg::addr_t addr,
	output mem_pkg::data_t wdata,
	input logic ack,
	input mem_pkg::data_t rdata,
	input logic rvalid,
	output logic busy,
	output logic test_done,
	output logic test_fail,
	output logic [15:0] err_count
);

typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ, S_DRAIN} state_t;

state_t state;
mem_pkg::addr_t wr_addr;
mem_pkg::addr_t rd_addr;
mem_pkg::addr_t chk_addr;
mem_pkg::data_t seed_q;
logic corrupt_q;
logic [15:0] wr_left;
logic [7:0] rq_left;
logic [15:0] rcv_left;
mem_pkg::data_t expected;
logic mismatch;

assign req = (state == S_WRITE) || (state == S_READ);
assign wr = (state == S_WRITE);
assign addr = wr ? wr_addr : rd_addr;

// Pattern is address XOR seed
assign wdata = mem_pkg::data_t'(wr_addr) ^ seed_q;
// Debug switch flips bit 0 of the expected word
assign expected = (mem_pkg::data_t'(chk_addr) ^ seed_q) ^ mem_pkg::data_t'(corrupt_q);
assign mismatch = rvalid && (rdata != expected);

always_ff @(posedge CLOCK_50) begin
	if (state == S_IDLE && start) begin
		wr_addr <= base;
		rd_addr <= base;
		chk_addr <= base;
		seed_q <= seed;
		corrupt_q <= corrupt;
		wr_left <= 16'(length) * 16'(`MEM_BURST);
		rq_left <= length;
		rcv_left <= 16'(length) * 16'(`MEM_BURST);
	end else begin
		if (ack && state == S_WRITE) begin
			wr_addr <= wr_addr + 1'b1;
			wr_left <= wr_left - 1'b1;
		end
		if (ack && state == S_READ) begin
			rd_addr <= rd_addr + mem_pkg::addr_t'(`MEM_BURST);
			rq_left <= rq_left - 1'b1;
		end
		if (rvalid) begin
			chk_addr <= chk_addr + 1'b1;
			rcv_left <= rcv_left - 1'b1;
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		busy <= 1'b0;
		test_done <= 1'b0;
		test_fail <= 1'b0;
		err_count <= '0;
	end else begin
		test_done <= 1'b0;
		case (state)
			S_IDLE: if (start) begin
				test_fail <= 1'b0;
				err_count <= '0;
				// Empty region finishes at once
				if (length == '0) begin
					test_done <= 1'b1;
				end else begin
					busy <= 1'b1;
					state <= S_WRITE;
				end
			end
			S_WRITE: if (ack && wr_left == 16'd1)
				state <= S_READ;
			S_READ: if (ack && rq_left == 8'd1)
				state <= S_DRAIN;
			S_DRAIN: if (rvalid && rcv_left == 16'd1) begin
				state <= S_IDLE;
				busy <= 1'b0;
				test_done <= 1'b1;
			end
			default: state <= S_IDLE;
		endcase
		if (mismatch) begin
			test_fail <= 1'b1;
			err_count <= err_count + 1'b1;
		end
	end
end

endmodule

`default_nettype wire

// File: source/mem_subsys_top.sv
// Memory subsystem top: arbiter, burst memory, display fetcher and self-test client
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_top (
	input logic CLOCK_50,
	input logic rst,
	input logic disp_enable,
	output disp_pkg::pixel_t pixel,
	output logic pixel_valid,
	input logic pixel_ready,
	output logic line_end,
	output logic frame_end,
	input logic test_start,
	input mem_pkg::addr_t test_base,
	input mem_pkg::data_t test_seed,
	input logic [7:0] test_length,
	input logic test_corrupt,
	output logic test_busy,
	output logic test_done,
	output logic test_fail,
	output logic [15:0] test_err_count
);

// Client request side, one entry per arbiter port
logic cl_req [`MEM_CLIENTS];
logic cl_wr [`MEM_CLIENTS];
mem_pkg::addr_t cl_addr [`MEM_CLIENTS];
mem_pkg::data_t cl_wdata [`MEM_CLIENTS];
logic [`MEM_CLIENTS-1:0] cl_ack;

// Command queue and read return
mem_pkg::mem_cmd_t cmd;
logic cmd_empty;
logic cmd_pop;
mem_pkg::data_t rdata;
logic [`MEM_CLIENTS-1:0] rvalid;

mem_arbiter u_mem_arbiter (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.req(cl_req),
	.wr(cl_wr),
	.addr(cl_addr),
	.wdata(cl_wdata),
	.ack(cl_ack),
	.cmd_pop(cmd_pop),
	.cmd(cmd),
	.cmd_empty(cmd_empty)
);

burst_mem u_burst_mem (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.cmd(cmd),
	.cmd_empty(cmd_empty),
	.cmd_pop(cmd_pop),
	.rdata(rdata),
	.rvalid(rvalid)
);

disp_fetch u_disp_fetch (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.enable(disp_enable),
	.req(cl_req[`CLIENT_DISP]),
	.wr(cl_wr[`CLIENT_DISP]),
	.addr(cl_addr[`CLIENT_DISP]),
	.wdata(cl_wdata[`CLIENT_DISP]),
	.ack(cl_ack[`CLIENT_DISP]),
	.rdata(rdata),
	.rvalid(rvalid[`CLIENT_DISP]),
	.pixel(pixel),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.line_end(line_end),
	.frame_end(frame_end)
);

mem_tester u_mem_tester (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(test_start),
	.base(test_base),
	.seed(test_seed),
	.length(test_length),
	.corrupt(test_corrupt),
	.req(cl_req[`CLIENT_TEST]),
	.wr(cl_wr[`CLIENT_TEST]),
	.addr(cl_addr[`CLIENT_TEST]),
	.wdata(cl_wdata[`CLIENT_TEST]),
	.ack(cl_ack[`CLIENT_TEST]),
	.rdata(rdata),
	.rvalid(rvalid[`CLIENT_TEST]),
	.busy(test_busy),
	.test_done(test_done),
	.test_fail(test_fail),
	.err_count(test_err_count)
);

endmodule

`default_nettype wire

// File: verif/mem_subsys_chk.sv
// Protocol assertions for the arbiter grants, read strobes and held requests
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_chk #(
	parameter int CW = `MEM_AW + 1 + `MEM_DW
) (
	input logic CLOCK_50,
	input logic rst,
	input logic [`MEM_CLIENTS-1:0] grant,
	input logic [`MEM_CLIENTS-1:0] hold_req,
	input logic [`MEM_CLIENTS-1:0] hold_ack,
	input logic [`MEM_CLIENTS-1:0][CW-1:0] hold_cmd
);

// At most one client served or strobed per cycle
grant_onehot: assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(grant))
	else $error("more than one grant or read strobe active");

// A waiting request keeps its address, direction and data
for (genvar c = 0; c < `MEM_CLIENTS; c++) begin : g_hold
	req_stable: assert property (@(posedge CLOCK_50) disable iff (rst)
		(hold_req[c] && !hold_ack[c]) |=> (hold_req[c] && $stable(hold_cmd[c])))
		else $error("client request changed before its ack");
end

endmodule

bind mem_arbiter mem_subsys_chk u_arb_chk (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.grant(ack),
	.hold_req({req[1], req[0]}),
	.hold_ack(ack),
	.hold_cmd({{addr[1], wr[1], wdata[1]}, {addr[0], wr[0], wdata[0]}})
);

// Queue head waits for its pop the way a client request waits for its ack
bind burst_mem mem_subsys_chk u_mem_chk (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.grant(rvalid),
	.hold_req({!cmd_empty && cmd.client == 1'b1, !cmd_empty && cmd.client == 1'b0}),
	.hold_ack({2{cmd_pop}}),
	.hold_cmd({2{cmd.addr, cmd.wr, cmd.wdata}})
);

`default_nettype wire

// File: verif/tb_mem_subsys.sv
// Memory subsystem testbench with scenario table, pixel stream monitor and timeout
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsys;

localparam int NROWS = 5;
localparam int FRAME = `FB_WIDTH * `FB_HEIGHT;
localparam int MIN_PIXELS = 4 * FRAME;
localparam mem_pkg::data_t FB_SEED = 16'h5a3c;

typedef struct {
	mem_pkg::addr_t base;
	mem_pkg::data_t seed;
	logic [7:0] length;
	logic corrupt;
	logic disp;
	logic [15:0] exp_err;
} row_t;

logic CLOCK_50;
logic rst;
logic disp_enable;
disp_pkg::pixel_t pixel;
logic pixel_valid;
logic pixel_ready;
logic line_end;
logic frame_end;
logic test_start;
mem_pkg::addr_t test_base;
mem_pkg::data_t test_seed;
logic [7:0] test_length;
logic test_corrupt;
logic test_busy;
logic test_done;
logic test_fail;
logic [15:0] test_err_count;

row_t rows [NROWS];
int errors;
int disp_errors;
int tests_run;
int tests_failed;
int pix_seen;
int cycles;
int cycle_limit;
logic hold_valid;
disp_pkg::pixel_t hold_pixel;
logic hold_line_end;
logic hold_frame_end;

mem_subsys_top u_mem_subsys_top (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.disp_enable(disp_enable),
	.pixel(pixel),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.line_end(line_end),
	.frame_end(frame_end),
	.test_start(test_start),
	.test_base(test_base),
	.test_seed(test_seed),
	.test_length(test_length),
	.test_corrupt(test_corrupt),
	.test_busy(test_busy),
	.test_done(test_done),
	.test_fail(test_fail),
	.test_err_count(test_err_count)
);

always #4 CLOCK_50 = ~CLOCK_50;

task automatic check_data(input string name, input mem_pkg::data_t exp,
	input mem_pkg::data_t act);
	if (exp !== act) begin
		errors++;
		$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
	end
endtask

task automatic check_pixel(input string name, input disp_pkg::pixel_t exp,
	input disp_pkg::pixel_t act);
	if (exp !== act) begin
		errors++;
		$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		errors++;
		$display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
	end
endtask

task automatic report_test(input string name, input bit ok);
	tests_run++;
	if (!ok)
		tests_failed++;
	$display("test %0d %s: %s", tests_run, name, ok ? "ok" : "FAILED");
endtask

// Rows 0 and 3 take random seeds; row 2 fills the frame buffer
task automatic fill_table;
	rows[0] = '{base: 10'h000, seed: mem_pkg::data_t'($urandom), length: 8'd4,
		corrupt: 1'b0, disp: 1'b0, exp_err: 16'd0};
	rows[1] = '{base: 10'h040, seed: 16'hc3a5, length: 8'd2,
		corrupt: 1'b1, disp: 1'b0, exp_err: 16'd16};
	rows[2] = '{base: mem_pkg::addr_t'(`FB_BASE), seed: FB_SEED,
		length: 8'(FRAME / `MEM_BURST), corrupt: 1'b0, disp: 1'b0, exp_err: 16'd0};
	rows[3] = '{base: 10'h200, seed: mem_pkg::data_t'($urandom), length: 8'd6,
		corrupt: 1'b0, disp: 1'b1, exp_err: 16'd0};
	rows[4] = '{base: 10'h300, seed: 16'h0f0f, length: 8'd3,
		corrupt: 1'b1, disp: 1'b1, exp_err: 16'd24};
	cycle_limit = 2000;
	for (int i = 0; i < NROWS; i++)
		cycle_limit += int'(rows[i].length) * `MEM_BURST * 6;
endtask

task automatic run_row(input int i);
	int e0;
	int d0;
	int row_err;
	e0 = errors;
	d0 = disp_errors;
	test_base <= rows[i].base;
	test_seed <= rows[i].seed;
	test_length <= rows[i].length;
	test_corrupt <= rows[i].corrupt;
	disp_enable <= rows[i].disp;
	test_start <= 1'b1;
	@(posedge CLOCK_50);
	test_start <= 1'b0;
	@(posedge CLOCK_50);
	check_flag("test_busy", 1'b1, test_busy);
	while (!test_done)
		@(posedge CLOCK_50);
	check_flag("test_fail", rows[i].exp_err != 16'd0, test_fail);
	check_data("test_err_count", rows[i].exp_err, test_err_count);
	check_flag("test_busy", 1'b0, test_busy);
	// Pixel errors seen meanwhile belong to the display test
	row_err = (errors - e0) - (disp_errors - d0);
	report_test($sformatf("tester row %0d base %h length %0d corrupt %b", i,
		rows[i].base, rows[i].length, rows[i].corrupt), row_err == 0);
endtask

// Random back-pressure on the pixel stream
always @(posedge CLOCK_50)
	pixel_ready <= ($urandom % 4) != 0;

// Stream monitor
// Pixel n comes from FB_BASE + n mod frame size
always @(posedge CLOCK_50) begin
	int e0;
	mem_pkg::data_t word;
	if (!rst) begin
		e0 = errors;
		if (hold_valid) begin
			check_flag("pixel_valid", 1'b1, pixel_valid);
			check_pixel("pixel", hold_pixel, pixel);
			check_flag("line_end", hold_line_end, line_end);
			check_flag("frame_end", hold_frame_end, frame_end);
		end
		if (pixel_valid && pixel_ready) begin
			word = mem_pkg::data_t'(`FB_BASE + pix_seen % FRAME) ^ FB_SEED;
			check_pixel("pixel", disp_pkg::pixel_t'(word), pixel);
			check_flag("line_end", pix_seen % `FB_WIDTH == `FB_WIDTH - 1, line_end);
			check_flag("frame_end", pix_seen % FRAME == FRAME - 1, frame_end);
			pix_seen++;
		end
		hold_valid = pixel_valid && !pixel_ready;
		hold_pixel = pixel;
		hold_line_end = line_end;
		hold_frame_end = frame_end;
		disp_errors += errors - e0;
	end
end

always @(posedge CLOCK_50) begin
	cycles++;
	if (cycles > cycle_limit) begin
		$display("Timeout: DUT did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end
end

initial begin
	int e0;
	CLOCK_50 = 1'b0;
	rst = 1'b1;
	disp_enable = 1'b0;
	pixel_ready = 1'b0;
	test_start = 1'b0;
	test_base = '0;
	test_seed = '0;
	test_length = '0;
	test_corrupt = 1'b0;
	errors = 0;
	disp_errors = 0;
	tests_run = 0;
	tests_failed = 0;
	pix_seen = 0;
	cycles = 0;
	hold_valid = 1'b0;
	void'($urandom(27459));
	fill_table();
	repeat (4) @(posedge CLOCK_50);
	rst <= 1'b0;
	@(posedge CLOCK_50);
	e0 = errors;
	check_flag("test_busy", 1'b0, test_busy);
	check_flag("test_done", 1'b0, test_done);
	check_flag("test_fail", 1'b0, test_fail);
	check_flag("pixel_valid", 1'b0, pixel_valid);
	check_flag("line_end", 1'b0, line_end);
	check_flag("frame_end", 1'b0, frame_end);
	report_test("outputs low after reset", errors == e0);
	for (int i = 0; i < NROWS; i++)
		run_row(i);
	// Several frames so the stream wraps more than once
	while (pix_seen < MIN_PIXELS)
		@(posedge CLOCK_50);
	report_test($sformatf("display stream of %0d pixels", pix_seen), disp_errors == 0);
	$display("Summary: %0d tests run, %0d failed, %0d check errors",
		tests_run, tests_failed, errors);
	if (tests_failed == 0 && errors == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/mem_pkg.sv
source/disp_pkg.sv
source/burst_fifo.sv
source/mem_arbiter.sv
source/burst_mem.sv
source/disp_fetch.sv
source/mem_tester.sv
source/mem_subsys_top.sv
verif/mem_subsys_chk.sv
verif/tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_mem_subsys -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^Simulation completed successfully$" && exit 0 || exit 1
